//--- verilog.f
common/video_pkg.sv
common/game_pkg.sv
verilog/screen_fill.sv
verilog/vga_scan.sv
playing/player_motion.sv
playing/player_render.sv
playing/playing_sequencer.sv
verilog/game_top.sv
tb/tb_clock.sv
tb/tb_frame_ram.sv
tb/tb_game.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_game
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_game.sv
`timescale 1ns/1ps

module tb_game;

    localparam int screen_width  = 16;
    localparam int screen_height = 8;
    localparam int tile_size     = 4;
    localparam int pixels        = screen_width * screen_height;
    localparam int centre_x      = screen_width / tile_size / 2;
    localparam int centre_y      = screen_height / tile_size / 2;
    localparam int event_timeout = 400;   // Cycles allowed between two bus events
    localparam int quiet_cycles  = 200;

    // Codes that must not steer the player
    localparam game_pkg::scan_code_t ignored_codes [6] = '{
        game_pkg::key_start, 8'h15, 8'h24, 8'h2D, 8'h5A, 8'h76
    };

    // One cycle with a RAM write or a VGA plot
    typedef struct packed {
        video_pkg::fb_write_t  write;
        video_pkg::vga_pixel_t pixel;
    } bus_event_t;

    logic                  clock;
    logic                  resetn;
    game_pkg::scan_code_t  last_key_received;
    video_pkg::color_t     fb_q;
    video_pkg::fb_write_t  fb_write;
    video_pkg::vga_pixel_t vga;

    bus_event_t events [$];
    int   seed;
    int   error_count;
    int   check_count;
    int   test_count;
    int   failed_tests;
    logic aborted;

    tb_clock #(.period(10), .reset_cycles(5)) clock_gen (.clock(clock), .resetn(resetn));

    tb_frame_ram ram (.clock(clock), .fb_write(fb_write), .fb_q(fb_q));

    game_top #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .tile_size     (tile_size)
    ) UUT (
        .clock             (clock),
        .resetn            (resetn),
        .last_key_received (last_key_received),
        .fb_q              (fb_q),
        .fb_write          (fb_write),
        .vga               (vga)
    );

    // Outputs are settled mid-cycle
    always @(negedge clock) begin
        if (resetn && (fb_write.wren || vga.plot)) begin
            events.push_back('{write: fb_write, pixel: vga});
        end
    end

    function automatic video_pkg::pixel_x_t column_of(input int index);
        return video_pkg::pixel_x_t'(index % screen_width);
    endfunction

    function automatic video_pkg::pixel_y_t row_of(input int index);
        return video_pkg::pixel_y_t'(index / screen_width);
    endfunction

    // Colour a pixel should hold, the fill or the player's tile on top of it
    function automatic video_pkg::color_t screen_color(input video_pkg::color_t fill,
                                                       input logic with_player,
                                                       input int tile_x, input int tile_y,
                                                       input int index);
        if (with_player && (index % screen_width) / tile_size == tile_x
                && (index / screen_width) / tile_size == tile_y) begin
            return video_pkg::player_color;
        end
        return fill;
    endfunction

    task automatic check_color(input video_pkg::color_t got, input video_pkg::color_t expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_pos(input video_pkg::pixel_x_t got_x, input video_pkg::pixel_y_t got_y,
                             input video_pkg::pixel_x_t exp_x, input video_pkg::pixel_y_t exp_y,
                             input string what);
        check_count++;
        if (got_x !== exp_x || got_y !== exp_y) begin
            error_count++;
            $display("Error at %0d ns: %s at (%0d,%0d), expected (%0d,%0d)",
                     $time, what, got_x, got_y, exp_x, exp_y);
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    // Whole screen in one colour, optionally with the player's tile on top
    task automatic check_ram(input video_pkg::color_t fill, input logic with_player,
                             input int tile_x, input int tile_y, input string what);
        for (int i = 0; i < pixels; i++) begin
            check_color(ram.mem[video_pkg::fb_addr_t'(i)],
                        screen_color(fill, with_player, tile_x, tile_y, i),
                        $sformatf("%s word %0d", what, i));
        end
    endtask

    task automatic next_event(input string what, output bus_event_t ev, output logic got);
        int cycles;
        cycles = 0;
        got    = 1'b0;
        while (events.size() == 0 && cycles < event_timeout) begin
            @(posedge clock);
            cycles++;
        end
        if (events.size() == 0) begin
            aborted = 1'b1;
            error_count++;
            $display("Timeout: no RAM write or VGA plot for %0d cycles during %s",
                     event_timeout, what);
        end else begin
            ev  = events.pop_front();
            got = 1'b1;
        end
    endtask

    task automatic drive_key(input game_pkg::scan_code_t code);
        @(posedge clock);
        #1;
        last_key_received = code;
    endtask

    // Expects one full-screen fill in raster order
    task automatic watch_fill(input video_pkg::color_t color, input string what);
        bus_event_t ev;
        logic       got;
        int         n;
        n = 0;
        while (n < pixels && !aborted) begin
            next_event(what, ev, got);
            if (got) begin
                check_flag(ev.write.wren, 1'b1, {what, " event is a RAM write"});
                check_color(ev.write.data, color, $sformatf("%s write %0d", what, n));
                check_pos(column_of(int'(ev.write.addr)), row_of(int'(ev.write.addr)),
                          column_of(n), row_of(n), $sformatf("%s write %0d", what, n));
                n++;
            end
        end
    endtask

    // Clear, render and scan of one playing frame
    task automatic run_frame(input int tile_x, input int tile_y, input string what);
        bus_event_t ev;
        logic       got;
        int         clears;
        int         draws;
        int         plots;
        int         sq;
        clears = 0;
        draws  = 0;
        plots  = 0;
        while (plots < pixels && !aborted) begin
            next_event(what, ev, got);
            if (got && ev.pixel.plot) begin
                check_flag(draws == tile_size * tile_size, 1'b1,
                           {what, " player drawn before scan"});
                check_pos(ev.pixel.x, ev.pixel.y, column_of(plots), row_of(plots),
                          $sformatf("%s plot %0d", what, plots));
                check_color(ev.pixel.color,
                            screen_color(video_pkg::background_color, 1'b1,
                                         tile_x, tile_y, plots),
                            $sformatf("%s plot %0d colour", what, plots));
                plots++;
            end else if (got && clears < pixels) begin
                check_color(ev.write.data, video_pkg::background_color,
                            $sformatf("%s clear %0d", what, clears));
                check_pos(column_of(int'(ev.write.addr)), row_of(int'(ev.write.addr)),
                          column_of(clears), row_of(clears), $sformatf("%s clear %0d", what, clears));
                clears++;
            end else if (got) begin
                // Square row by row from its top-left pixel
                sq = (tile_y * tile_size + draws / tile_size) * screen_width
                     + tile_x * tile_size + draws % tile_size;
                check_color(ev.write.data, video_pkg::player_color,
                            $sformatf("%s draw %0d", what, draws));
                check_pos(column_of(int'(ev.write.addr)), row_of(int'(ev.write.addr)),
                          column_of(sq), row_of(sq), $sformatf("%s draw %0d", what, draws));
                draws++;
            end
        end
        if (!aborted) check_ram(video_pkg::background_color, 1'b1, tile_x, tile_y, what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
            $display("%s: FAILED, %0d errors", name, error_count - errors_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic greeting_after_reset();
        int errors_before;
        int cycles;
        errors_before = error_count;
        cycles        = 0;
        while (resetn !== 1'b1 && cycles < 50) begin
            @(negedge clock);
            if (!resetn) begin
                check_flag(vga.plot, 1'b0, "plot during reset");
                check_flag(fb_write.wren, 1'b0, "write during reset");
            end
            cycles++;
        end
        if (resetn !== 1'b1) begin
            aborted = 1'b1;
            error_count++;
            $display("Timeout: reset was never released");
        end
        if (!aborted) watch_fill(video_pkg::greeting_color, "greeting fill");
        cycles = 0;
        while (!aborted && cycles < quiet_cycles) begin
            @(posedge clock);
            cycles++;
        end
        check_flag(events.size() == 0, 1'b1, "bus quiet without start key");
        check_ram(video_pkg::greeting_color, 1'b0, 0, 0, "greeting screen");
        finish_test("reset_greeting", errors_before);
    endtask

    task automatic first_frame();
        int errors_before;
        errors_before = error_count;
        drive_key(game_pkg::key_start);
        run_frame(centre_x, centre_y, "first frame");
        finish_test("first_frame", errors_before);
    endtask

    task automatic ignored_keys();
        int errors_before;
        int idx;
        errors_before = error_count;
        for (int frame = 0; frame < 2 && !aborted; frame++) begin
            idx = $unsigned($random(seed)) % 6;
            drive_key(ignored_codes[idx]);
            run_frame(centre_x, centre_y, $sformatf("ignored key %h frame", ignored_codes[idx]));
        end
        finish_test("ignored_keys", errors_before);
    endtask

    task automatic move_left();
        int errors_before;
        errors_before = error_count;
        drive_key(game_pkg::key_left);
        for (int frame = 1; frame <= centre_x && !aborted; frame++) begin
            run_frame(centre_x - frame, centre_y, $sformatf("left move %0d", frame));
        end
        finish_test("move_left", errors_before);
    endtask

    task automatic wall_game_over();
        int errors_before;
        errors_before = error_count;
        watch_fill(video_pkg::background_color, "wall frame clear");
        if (!aborted) watch_fill(video_pkg::game_over_color, "game over fill");
        if (!aborted) begin
            @(negedge clock);   // Last write has landed, greeting not yet started
            check_ram(video_pkg::game_over_color, 1'b0, 0, 0, "game over screen");
            watch_fill(video_pkg::greeting_color, "greeting refill");
        end
        finish_test("wall_game_over", errors_before);
    endtask

    initial begin
        last_key_received = 8'h00;
        seed              = 24159;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        aborted           = 1'b0;

        greeting_after_reset();
        if (!aborted) first_frame();
        if (!aborted) ignored_keys();   // Direction still NONE here
        if (!aborted) move_left();
        if (!aborted) wall_game_over();

        $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_frame_ram.sv
`timescale 1ns/1ps

// Single-port frame buffer, read data one cycle after the address
module tb_frame_ram (
    input  logic                 clock,
    input  video_pkg::fb_write_t fb_write,
    output video_pkg::color_t    fb_q
);

    video_pkg::color_t mem [32768];   // Whole fb_addr_t range
    video_pkg::color_t q = '0;

    always @(posedge clock) begin
        if (fb_write.wren) begin
            mem[fb_write.addr] <= fb_write.data;
        end
        q <= mem[fb_write.addr];   // Old word on a write cycle
    end

    assign fb_q = q;

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

// Free-running clock and a synchronous, active-low reset pulse
module tb_clock #(
    parameter int period       = 10,
    parameter int reset_cycles = 5
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1 resetn = 1'b1;   // Released just after the edge, like the other inputs
    end

endmodule

//--- verilog/game_top.sv
`timescale 1ns/1ps

module game_top #(
    parameter int screen_width  = 160,
    parameter int screen_height = 120,
    parameter int tile_size     = 4
) (
    input  logic                   clock,
    input  logic                   resetn,
    input  game_pkg::scan_code_t   last_key_received,
    input  video_pkg::color_t      fb_q,
    output video_pkg::fb_write_t   fb_write,
    output video_pkg::vga_pixel_t  vga
);

    game_pkg::game_phase_t phase, next_phase;

    logic greet_done, over_done, play_finished;
    logic greet_filled;   // Greeting screen complete, waiting for space

    video_pkg::fb_write_t  greet_write, over_write, play_write;
    video_pkg::vga_pixel_t play_vga;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase <= game_pkg::GREETING;
        end else begin
            phase <= next_phase;
        end
    end

    // The fill pulses done once, the key may come much later
    always_ff @(posedge clock) begin
        if (!resetn || phase != game_pkg::GREETING) begin
            greet_filled <= 1'b0;
        end else if (greet_done) begin
            greet_filled <= 1'b1;
        end
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            game_pkg::GREETING:
                if (greet_filled && last_key_received == game_pkg::key_start)
                    next_phase = game_pkg::PLAYING;
            game_pkg::PLAYING:
                if (play_finished) next_phase = game_pkg::GAME_OVER;
            game_pkg::GAME_OVER:
                if (over_done) next_phase = game_pkg::GREETING;
            default: next_phase = game_pkg::GREETING;
        endcase
    end

    // Only the active phase reaches the RAM and the VGA adapter
    always_comb begin
        fb_write = '0;
        vga      = '0;
        case (phase)
            game_pkg::GREETING:  fb_write = greet_write;
            game_pkg::PLAYING: begin
                fb_write = play_write;
                vga      = play_vga;
            end
            game_pkg::GAME_OVER: fb_write = over_write;
            default: ;
        endcase
    end

    screen_fill #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .fill_color    (video_pkg::greeting_color)
    ) u_greeting (
        .clock    (clock),
        .resetn   (resetn),
        .start    (phase == game_pkg::GREETING),
        .done     (greet_done),
        .fb_write (greet_write)
    );

    playing_sequencer #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .tile_size     (tile_size)
    ) u_playing (
        .clock             (clock),
        .resetn            (resetn),
        .start             (phase == game_pkg::PLAYING),
        .finished          (play_finished),
        .last_key_received (last_key_received),
        .fb_q              (fb_q),
        .fb_write          (play_write),
        .vga               (play_vga)
    );

    screen_fill #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .fill_color    (video_pkg::game_over_color)
    ) u_game_over (
        .clock    (clock),
        .resetn   (resetn),
        .start    (phase == game_pkg::GAME_OVER),
        .done     (over_done),
        .fb_write (over_write)
    );

    // RAM writes and VGA plots come from different phases
    a_write_plot_exclusive: assert property (
        @(posedge clock) disable iff (!resetn) !(fb_write.wren && vga.plot)
    );

endmodule

//--- playing/playing_sequencer.sv
`timescale 1ns/1ps

module playing_sequencer #(
    parameter int screen_width  = 160,
    parameter int screen_height = 120,
    parameter int tile_size     = 4
) (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  start,
    output logic                  finished,
    input  game_pkg::scan_code_t  last_key_received,
    input  video_pkg::color_t     fb_q,
    output video_pkg::fb_write_t  fb_write,
    output video_pkg::vga_pixel_t vga
);

    game_pkg::play_phase_t state, next_state;
    game_pkg::player_pos_t player_pos;

    logic clear_done, render_done, scan_done;
    logic moved, hit_wall;

    video_pkg::fb_write_t  clear_write, render_write;
    video_pkg::fb_addr_t   scan_addr;
    video_pkg::vga_pixel_t scan_vga;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= game_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            game_pkg::IDLE:            if (start) next_state = game_pkg::CLEAR_SCREEN;
            game_pkg::CLEAR_SCREEN:    if (clear_done) next_state = game_pkg::UPDATE_POSITION;
            game_pkg::UPDATE_POSITION: begin
                if (hit_wall) next_state = game_pkg::FINISH;
                else if (moved) next_state = game_pkg::RENDER_PLAYER;
            end
            game_pkg::RENDER_PLAYER:   if (render_done) next_state = game_pkg::UPDATE_VGA;
            game_pkg::UPDATE_VGA:      if (scan_done) next_state = game_pkg::CLEAR_SCREEN;
            game_pkg::FINISH:          next_state = game_pkg::IDLE;
            default:                   next_state = game_pkg::IDLE;
        endcase
        if (!start) next_state = game_pkg::IDLE;   // Parent left the playing phase
    end

    assign finished = (state == game_pkg::FINISH);

    always_comb begin
        fb_write = '0;
        vga      = '0;
        case (state)
            game_pkg::CLEAR_SCREEN:  fb_write = clear_write;
            game_pkg::RENDER_PLAYER: fb_write = render_write;
            game_pkg::UPDATE_VGA: begin
                fb_write.addr = scan_addr;   // Read only
                vga           = scan_vga;
            end
            default: ;
        endcase
    end

    screen_fill #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .fill_color    (video_pkg::background_color)
    ) u_clear (
        .clock    (clock),
        .resetn   (resetn),
        .start    (state == game_pkg::CLEAR_SCREEN),
        .done     (clear_done),
        .fb_write (clear_write)
    );

    player_motion #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .tile_size     (tile_size)
    ) u_motion (
        .clock             (clock),
        .resetn            (resetn),
        .restart           (state == game_pkg::IDLE),
        .last_key_received (last_key_received),
        .step              (state == game_pkg::UPDATE_POSITION),
        .moved             (moved),
        .hit_wall          (hit_wall),
        .pos               (player_pos)
    );

    player_render #(
        .screen_width (screen_width),
        .tile_size    (tile_size)
    ) u_render (
        .clock    (clock),
        .resetn   (resetn),
        .start    (state == game_pkg::RENDER_PLAYER),
        .pos      (player_pos),
        .done     (render_done),
        .fb_write (render_write)
    );

    vga_scan #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    ) u_scan (
        .clock   (clock),
        .resetn  (resetn),
        .start   (state == game_pkg::UPDATE_VGA),
        .done    (scan_done),
        .fb_addr (scan_addr),
        .fb_q    (fb_q),
        .vga     (scan_vga)
    );

    // Player square stays inside the frame buffer
    a_render_on_screen: assert property (
        @(posedge clock) disable iff (!resetn)
        render_write.wren |->
            render_write.addr < video_pkg::fb_addr_t'(screen_width * screen_height)
    );

endmodule

//--- playing/player_render.sv
`timescale 1ns/1ps

// Draws the player as a filled tile, row by row
module player_render #(
    parameter int screen_width = 160,
    parameter int tile_size    = 4
) (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  start,
    input  game_pkg::player_pos_t pos,
    output logic                  done,
    output video_pkg::fb_write_t  fb_write
);

    video_pkg::pixel_x_t dx, px;   // Offset inside the tile, screen column
    video_pkg::pixel_y_t dy, py;
    logic drawn;
    logic end_of_row;
    logic last_pixel;

    assign end_of_row = (dx == video_pkg::pixel_x_t'(tile_size - 1));
    assign last_pixel = end_of_row && (dy == video_pkg::pixel_y_t'(tile_size - 1));

    assign px = video_pkg::pixel_x_t'(pos.x * tile_size) + dx;
    assign py = video_pkg::pixel_y_t'(pos.y * tile_size) + dy;

    always_ff @(posedge clock) begin
        if (!resetn || !start) begin
            dx    <= '0;
            dy    <= '0;
            drawn <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!drawn) begin
                if (end_of_row) begin
                    dx <= '0;
                    dy <= dy + 1'b1;
                end else begin
                    dx <= dx + 1'b1;
                end
                if (last_pixel) begin
                    drawn <= 1'b1;
                    done  <= 1'b1;
                end
            end
        end
    end

    assign fb_write = '{
        addr: video_pkg::fb_addr_t'(py * screen_width + px),
        data: video_pkg::player_color,
        wren: start && !drawn
    };

endmodule

//--- playing/player_motion.sv
`timescale 1ns/1ps

module player_motion #(
    parameter int screen_width  = 160,
    parameter int screen_height = 120,
    parameter int tile_size     = 4
) (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  restart,
    input  game_pkg::scan_code_t  last_key_received,
    input  logic                  step,
    output logic                  moved,
    output logic                  hit_wall,
    output game_pkg::player_pos_t pos
);

    localparam int grid_width  = screen_width / tile_size;
    localparam int grid_height = screen_height / tile_size;

    localparam game_pkg::player_pos_t centre = '{
        x: game_pkg::tile_x_t'(grid_width / 2),
        y: game_pkg::tile_y_t'(grid_height / 2)
    };

    game_pkg::direction_t  dir;
    game_pkg::player_pos_t next_pos;
    logic blocked;   // Target tile is off the grid

    always_comb begin
        next_pos = pos;
        blocked  = 1'b0;
        case (dir)
            game_pkg::UP:
                if (pos.y == '0) blocked = 1'b1;
                else next_pos.y = pos.y - 1'b1;
            game_pkg::LEFT:
                if (pos.x == '0) blocked = 1'b1;
                else next_pos.x = pos.x - 1'b1;
            game_pkg::DOWN:
                if (pos.y == game_pkg::tile_y_t'(grid_height - 1)) blocked = 1'b1;
                else next_pos.y = pos.y + 1'b1;
            game_pkg::RIGHT:
                if (pos.x == game_pkg::tile_x_t'(grid_width - 1)) blocked = 1'b1;
                else next_pos.x = pos.x + 1'b1;
            default: ;   // NONE stays put
        endcase
    end

    assign moved    = step && !blocked;
    assign hit_wall = step && blocked;

    always_ff @(posedge clock) begin
        if (!resetn || restart) begin
            dir <= game_pkg::NONE;
            pos <= centre;
        end else begin
            case (last_key_received)
                game_pkg::key_up:    dir <= game_pkg::UP;
                game_pkg::key_left:  dir <= game_pkg::LEFT;
                game_pkg::key_down:  dir <= game_pkg::DOWN;
                game_pkg::key_right: dir <= game_pkg::RIGHT;
                default: ;   // Other codes keep the direction
            endcase
            if (moved) pos <= next_pos;
        end
    end

endmodule

//--- verilog/vga_scan.sv
`timescale 1ns/1ps

// Copies the frame buffer to the VGA adapter in raster order
module vga_scan #(
    parameter int screen_width  = 160,
    parameter int screen_height = 120
) (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  start,
    output logic                  done,
    output video_pkg::fb_addr_t   fb_addr,
    input  video_pkg::color_t     fb_q,
    output video_pkg::vga_pixel_t vga
);

    video_pkg::pixel_x_t x, x_d;
    video_pkg::pixel_y_t y, y_d;
    logic scanned;
    logic reading;
    logic plot_d;
    logic last_d;      // Last read is in flight
    logic end_of_row;
    logic last_pixel;

    assign reading    = start && !scanned;
    assign end_of_row = (x == video_pkg::pixel_x_t'(screen_width - 1));
    assign last_pixel = end_of_row && (y == video_pkg::pixel_y_t'(screen_height - 1));

    always_ff @(posedge clock) begin
        if (!resetn || !start) begin
            x       <= '0;
            y       <= '0;
            fb_addr <= '0;
            scanned <= 1'b0;
            plot_d  <= 1'b0;
            last_d  <= 1'b0;
            done    <= 1'b0;
        end else begin
            plot_d <= reading;
            last_d <= reading && last_pixel;
            done   <= last_d;
            if (reading) begin
                fb_addr <= fb_addr + 1'b1;
                if (end_of_row) begin
                    x <= '0;
                    y <= y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
                if (last_pixel) scanned <= 1'b1;
            end
        end
    end

    // Coordinates wait one cycle for the RAM data
    always_ff @(posedge clock) begin
        x_d <= x;
        y_d <= y;
    end

    assign vga = '{x: x_d, y: y_d, color: fb_q, plot: plot_d};

    // Each plot matches the address read the cycle before
    a_plot_follows_read: assert property (
        @(posedge clock) disable iff (!resetn)
        vga.plot |-> $past(reading) &&
            $past(fb_addr) == video_pkg::fb_addr_t'(vga.y * screen_width + vga.x)
    );

endmodule

//--- verilog/screen_fill.sv
`timescale 1ns/1ps

// Paints fill_color over the whole frame buffer, one pixel per clock
module screen_fill #(
    parameter int                screen_width  = 160,
    parameter int                screen_height = 120,
    parameter video_pkg::color_t fill_color    = 12'h000
) (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 start,
    output logic                 done,
    output video_pkg::fb_write_t fb_write
);

    video_pkg::pixel_x_t x;
    video_pkg::pixel_y_t y;
    video_pkg::fb_addr_t addr;
    logic filled;      // Stays set until start drops
    logic end_of_row;
    logic last_pixel;

    assign end_of_row = (x == video_pkg::pixel_x_t'(screen_width - 1));
    assign last_pixel = end_of_row && (y == video_pkg::pixel_y_t'(screen_height - 1));

    always_ff @(posedge clock) begin
        if (!resetn || !start) begin
            x      <= '0;
            y      <= '0;
            addr   <= '0;
            filled <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!filled) begin
                addr <= addr + 1'b1;   // Raster order, so address just counts
                if (end_of_row) begin
                    x <= '0;
                    y <= y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
                if (last_pixel) begin
                    filled <= 1'b1;
                    done   <= 1'b1;
                end
            end
        end
    end

    // No writes while held in reset
    assign fb_write = '{addr: addr, data: fill_color, wren: resetn && start && !filled};

endmodule

//--- common/game_pkg.sv
package game_pkg;

    // Top-level game phases
    typedef enum logic [1:0] {
        GREETING,
        PLAYING,
        GAME_OVER
    } game_phase_t;

    // Steps of one playing frame
    typedef enum logic [2:0] {
        IDLE,
        CLEAR_SCREEN,
        UPDATE_POSITION,
        RENDER_PLAYER,
        UPDATE_VGA,
        FINISH
    } play_phase_t;

    typedef logic [7:0] scan_code_t;   // PS/2 make code

    localparam scan_code_t key_up    = 8'h1D;   // W
    localparam scan_code_t key_left  = 8'h1C;   // A
    localparam scan_code_t key_down  = 8'h1B;   // S
    localparam scan_code_t key_right = 8'h23;   // D
    localparam scan_code_t key_start = 8'h29;   // Space

    typedef enum logic [2:0] {
        NONE,
        UP,
        LEFT,
        DOWN,
        RIGHT
    } direction_t;

    // Tile grid coordinates
    typedef logic [5:0] tile_x_t;
    typedef logic [4:0] tile_y_t;

    typedef struct packed {
        tile_x_t x;
        tile_y_t y;
    } player_pos_t;

endpackage

//--- common/video_pkg.sv
package video_pkg;

    // Screen coordinates and frame-buffer address
    typedef logic [7:0]  pixel_x_t;
    typedef logic [6:0]  pixel_y_t;
    typedef logic [14:0] fb_addr_t;   // row * screen width + column

    typedef logic [11:0] color_t;     // 4 bits each of R, G, B

    // One frame-buffer RAM access, read when wren is low
    typedef struct packed {
        fb_addr_t addr;
        color_t   data;
        logic     wren;
    } fb_write_t;

    // Pixel handed to the VGA adapter
    typedef struct packed {
        pixel_x_t x;
        pixel_y_t y;
        color_t   color;
        logic     plot;   // Single-cycle write strobe
    } vga_pixel_t;

    localparam color_t greeting_color   = 12'h0F0;
    localparam color_t background_color = 12'h000;
    localparam color_t player_color     = 12'hFF0;
    localparam color_t game_over_color  = 12'hF00;

endpackage
